// File: Makefile
# Verilator build and run for the bus unit testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bus_arbiter/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rd_req_t    ifu_req_i,
  output rd_rsp_t    ifu_rsp_o,
  input  rd_req_t    lsu_rd_req_i,
  output rd_rsp_t    lsu_rd_rsp_o,
  input  wr_req_t    lsu_wr_req_i,
  output wr_rsp_t    lsu_wr_rsp_o,
  output addr_t      m_araddr_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,
  input  data_t      m_rdata_i,
  input  logic       m_rvalid_i,
  output logic       m_rready_o,
  output addr_t      m_awaddr_o,
  output logic       m_awvalid_o,
  input  logic       m_awready_i,
  output data_t      m_wdata_o,
  output strb_t      m_wstrb_o,
  output logic       m_wvalid_o,
  input  logic       m_wready_i,
  input  logic       m_bvalid_i,
  output logic       m_bready_o,
  output logic       tmr_rd_o,
  output logic       tmr_hi_o,
  input  data_t      tmr_rdata_i,
  output logic       tx_wr_o,
  output logic [7:0] tx_byte_o,
  input  logic       tx_wr_ready_i
);

  // owner of the transaction in flight
  localparam logic [1:0] OWN_IFU = 2'd0;
  localparam logic [1:0] OWN_LD  = 2'd1;
  localparam logic [1:0] OWN_ST  = 2'd2;

  arb_state_t state_q;
  logic [1:0] owner_q;
  logic       arvalid_q;
  logic       awvalid_q;
  logic       wvalid_q;
  logic       tmr_rd_q;
  logic       tx_wr_q;
  logic       rsp_valid_q;
  logic       rsp_tmr_q;
  data_t      rsp_data_q;
  data_t      rsp_data;
  addr_t      addr_q;
  data_t      wdata_q;
  strb_t      wstrb_q;

  logic busy;
  logic can_grant;
  logic st_sel;
  logic ld_sel;
  logic if_sel;
  logic ld_tmr;
  logic st_tx;
  logic aw_done;
  logic w_done;

  // device access or response pulse still pending
  assign busy      = tmr_rd_q | tx_wr_q | rsp_valid_q;
  assign can_grant = (state_q == IDLE) && !busy;

  // fixed priority: store, load, fetch
  assign st_sel = lsu_wr_req_i.valid;
  assign ld_sel = !st_sel && lsu_rd_req_i.valid;
  assign if_sel = !st_sel && !ld_sel && ifu_req_i.valid;

  assign ld_tmr = (lsu_rd_req_i.addr == CLINT_MTIME_LO) ||
                  (lsu_rd_req_i.addr == CLINT_MTIME_HI);
  assign st_tx  = (lsu_wr_req_i.addr == SERIAL_PORT_ADDR);

  // handshake seen now or in an earlier cycle
  assign aw_done = !awvalid_q || m_awready_i;
  assign w_done  = !wvalid_q || m_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= IDLE;
      owner_q     <= OWN_IFU;
      arvalid_q   <= 1'b0;
      awvalid_q   <= 1'b0;
      wvalid_q    <= 1'b0;
      tmr_rd_q    <= 1'b0;
      tx_wr_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_tmr_q   <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= 1'b0;
      tmr_rd_q    <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (tmr_rd_q)
          begin
            // timer data shows up together with the pulse
            rsp_valid_q <= 1'b1;
            rsp_tmr_q   <= 1'b1;
          end
          else if (tx_wr_q)
          begin
            if (tx_wr_ready_i)
            begin
              tx_wr_q     <= 1'b0;
              rsp_valid_q <= 1'b1;
              rsp_tmr_q   <= 1'b0;
            end
          end
          else if (can_grant)
          begin
            if (st_sel)
            begin
              owner_q <= OWN_ST;
              if (st_tx)
              begin
                tx_wr_q <= 1'b1;
              end
              else
              begin
                awvalid_q <= 1'b1;
                wvalid_q  <= 1'b1;
                state_q   <= WR_ADDR_DATA;
              end
            end
            else if (ld_sel)
            begin
              owner_q <= OWN_LD;
              if (ld_tmr)
              begin
                tmr_rd_q <= 1'b1;
              end
              else
              begin
                arvalid_q <= 1'b1;
                state_q   <= RD_ADDR;
              end
            end
            else if (if_sel)
            begin
              owner_q   <= OWN_IFU;
              arvalid_q <= 1'b1;
              state_q   <= RD_ADDR;
            end
          end
        end
        RD_ADDR:
        begin
          if (m_arready_i)
          begin
            arvalid_q <= 1'b0;
            state_q   <= RD_DATA;
          end
        end
        RD_DATA:
        begin
          if (m_rvalid_i)
          begin
            rsp_valid_q <= 1'b1;
            rsp_tmr_q   <= 1'b0;
            state_q     <= IDLE;
          end
        end
        WR_ADDR_DATA:
        begin
          // aw and w may finish in either order
          if (m_awready_i)
          begin
            awvalid_q <= 1'b0;
          end
          if (m_wready_i)
          begin
            wvalid_q <= 1'b0;
          end
          if (aw_done && w_done)
          begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP:
        begin
          if (m_bvalid_i)
          begin
            rsp_valid_q <= 1'b1;
            rsp_tmr_q   <= 1'b0;
            state_q     <= IDLE;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address and write payload taken at grant time
  always_ff @(posedge clk)
  begin
    if (can_grant)
    begin
      if (st_sel)
      begin
        addr_q  <= lsu_wr_req_i.addr;
        wdata_q <= lsu_wr_req_i.data;
        wstrb_q <= lsu_wr_req_i.strb;
      end
      else if (ld_sel)
      begin
        addr_q <= lsu_rd_req_i.addr;
      end
      else
      begin
        addr_q <= ifu_req_i.addr;
      end
    end
    if ((state_q == RD_DATA) && m_rvalid_i)
    begin
      rsp_data_q <= m_rdata_i;
    end
  end

  assign m_araddr_o  = addr_q;
  assign m_arvalid_o = arvalid_q;
  assign m_rready_o  = (state_q == RD_DATA);
  assign m_awaddr_o  = addr_q;
  assign m_awvalid_o = awvalid_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;
  assign m_wvalid_o  = wvalid_q;
  assign m_bready_o  = (state_q == WR_RESP);

  // requests are held, so select and byte come straight from them
  assign tmr_rd_o  = tmr_rd_q;
  assign tmr_hi_o  = (lsu_rd_req_i.addr == CLINT_MTIME_HI);
  assign tx_wr_o   = tx_wr_q;
  assign tx_byte_o = lsu_wr_req_i.data[7:0];

  assign rsp_data = rsp_tmr_q ? tmr_rdata_i : rsp_data_q;

  // only the owner sees the pulse
  assign ifu_rsp_o    = '{valid: rsp_valid_q && (owner_q == OWN_IFU), data: rsp_data};
  assign lsu_rd_rsp_o = '{valid: rsp_valid_q && (owner_q == OWN_LD), data: rsp_data};
  assign lsu_wr_rsp_o = '{done: rsp_valid_q && (owner_q == OWN_ST)};

endmodule

// File: common/bus_pkg.sv
package bus_pkg;

  // widths that carry a meaning on the core side
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // core-local timer words
  localparam addr_t CLINT_MTIME_LO = 32'h0200_bff8;
  localparam addr_t CLINT_MTIME_HI = 32'h0200_bffc;

  // serial port transmit register
  localparam addr_t SERIAL_PORT_ADDR = 32'h1000_0000;

  // fetch or load request, held until the response pulse
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  // read response, valid is a one-cycle pulse
  typedef struct packed {
    logic  valid;
    data_t data;
  } rd_rsp_t;

  // store request, held until done
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_req_t;

  typedef struct packed {
    logic done;
  } wr_rsp_t;

  // memory side sequence of the arbiter
  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_ADDR_DATA,
    WR_RESP
  } arb_state_t;

endpackage

// File: src/bus_top.sv
`timescale 1ns/1ps

module bus_top
  import bus_pkg::*;
#(
  parameter int TICK_DIV = 4
)
(
  input  logic       clk,
  input  logic       rst,
  input  rd_req_t    ifu_req_i,
  output rd_rsp_t    ifu_rsp_o,
  input  rd_req_t    lsu_rd_req_i,
  output rd_rsp_t    lsu_rd_rsp_o,
  input  wr_req_t    lsu_wr_req_i,
  output wr_rsp_t    lsu_wr_rsp_o,
  output addr_t      m_araddr_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,
  input  data_t      m_rdata_i,
  input  logic       m_rvalid_i,
  output logic       m_rready_o,
  output addr_t      m_awaddr_o,
  output logic       m_awvalid_o,
  input  logic       m_awready_i,
  output data_t      m_wdata_o,
  output strb_t      m_wstrb_o,
  output logic       m_wvalid_o,
  input  logic       m_wready_i,
  input  logic       m_bvalid_i,
  output logic       m_bready_o,
  output logic [7:0] tx_byte_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i
);

  // timer read path
  logic  tmr_rd;
  logic  tmr_hi;
  data_t tmr_rdata;

  // serial store path
  logic       tx_wr;
  logic [7:0] tx_wr_byte;
  logic       tx_wr_ready;

  bus_arbiter arb_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_req_i     (ifu_req_i),
    .ifu_rsp_o     (ifu_rsp_o),
    .lsu_rd_req_i  (lsu_rd_req_i),
    .lsu_rd_rsp_o  (lsu_rd_rsp_o),
    .lsu_wr_req_i  (lsu_wr_req_i),
    .lsu_wr_rsp_o  (lsu_wr_rsp_o),
    .m_araddr_o    (m_araddr_o),
    .m_arvalid_o   (m_arvalid_o),
    .m_arready_i   (m_arready_i),
    .m_rdata_i     (m_rdata_i),
    .m_rvalid_i    (m_rvalid_i),
    .m_rready_o    (m_rready_o),
    .m_awaddr_o    (m_awaddr_o),
    .m_awvalid_o   (m_awvalid_o),
    .m_awready_i   (m_awready_i),
    .m_wdata_o     (m_wdata_o),
    .m_wstrb_o     (m_wstrb_o),
    .m_wvalid_o    (m_wvalid_o),
    .m_wready_i    (m_wready_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_bready_o    (m_bready_o),
    .tmr_rd_o      (tmr_rd),
    .tmr_hi_o      (tmr_hi),
    .tmr_rdata_i   (tmr_rdata),
    .tx_wr_o       (tx_wr),
    .tx_byte_o     (tx_wr_byte),
    .tx_wr_ready_i (tx_wr_ready)
  );

  clint_timer #(
    .TICK_DIV (TICK_DIV)
  ) timer_i (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (tmr_rd),
    .hi_i    (tmr_hi),
    .rdata_o (tmr_rdata)
  );

  uart_tx_reg tx_i (
    .clk        (clk),
    .rst        (rst),
    .wr_i       (tx_wr),
    .byte_i     (tx_wr_byte),
    .wr_ready_o (tx_wr_ready),
    .tx_byte_o  (tx_byte_o),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i)
  );

endmodule

// File: src/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
  import bus_pkg::*;
#(
  parameter int TICK_DIV = 4
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_i,
  input  logic  hi_i,
  output data_t rdata_o
);

  // prescaler needs at least one bit
  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] div_cnt_q;
  logic [63:0]      mtime_q;
  logic             tick;

  assign tick = (div_cnt_q == CNT_LAST);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt_q <= '0;
      mtime_q   <= '0;
    end
    else
    begin
      if (tick)
      begin
        div_cnt_q <= '0;
        mtime_q   <= mtime_q + 64'd1;
      end
      else
      begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  // selected half is held until the next read
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      rdata_o <= hi_i ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

endmodule

// File: src/uart_tx_reg.sv
`timescale 1ns/1ps

module uart_tx_reg (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr_i,
  input  logic [7:0] byte_i,
  output logic       wr_ready_o,
  output logic [7:0] tx_byte_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i
);

  logic       full_q;
  logic [7:0] buf_q;
  logic       accept;
  logic       drain;

  // a byte is taken only into an empty buffer
  assign accept = wr_i && !full_q;
  assign drain  = full_q && tx_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full_q <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        full_q <= 1'b1;
      end
      else if (drain)
      begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      buf_q <= byte_i;
    end
  end

  assign wr_ready_o = !full_q;
  assign tx_valid_o = full_q;
  assign tx_byte_o  = buf_q;

endmodule

// File: tb.f
common/bus_pkg.sv
src/clint_timer.sv
src/uart_tx_reg.sv
bus_arbiter/bus_arbiter.sv
src/bus_top.sv
verification/bus_checker.sv
verification/tb_bus_top.sv

// File: verification/bus_checker.sv
`timescale 1ns/1ps

module bus_checker
  import bus_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  arvalid_i,
  input logic  arready_i,
  input addr_t araddr_i,
  input logic  awvalid_i,
  input logic  awready_i,
  input addr_t awaddr_i,
  input logic  wvalid_i,
  input logic  wready_i,
  input data_t wdata_i,
  input strb_t wstrb_i,
  input logic  ifu_rsp_i,
  input logic  ld_rsp_i,
  input logic  st_done_i
);

  // valids hold with a stable payload until ready
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("AR valid dropped or address changed before ready");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("AW valid dropped or address changed before ready");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("W valid dropped or data changed before ready");

  // responses are single-cycle pulses
  ifu_pulse: assert property (@(posedge clk) disable iff (rst) ifu_rsp_i |=> !ifu_rsp_i)
    else $error("fetch response longer than one cycle");

  ld_pulse: assert property (@(posedge clk) disable iff (rst) ld_rsp_i |=> !ld_rsp_i)
    else $error("load response longer than one cycle");

  st_pulse: assert property (@(posedge clk) disable iff (rst) st_done_i |=> !st_done_i)
    else $error("store done longer than one cycle");

  // one transaction in flight
  rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(arvalid_i && awvalid_i))
    else $error("AR and AW valid at the same time");

endmodule

bind bus_arbiter bus_checker chk_i (
  .clk       (clk),
  .rst       (rst),
  .arvalid_i (m_arvalid_o),
  .arready_i (m_arready_i),
  .araddr_i  (m_araddr_o),
  .awvalid_i (m_awvalid_o),
  .awready_i (m_awready_i),
  .awaddr_i  (m_awaddr_o),
  .wvalid_i  (m_wvalid_o),
  .wready_i  (m_wready_i),
  .wdata_i   (m_wdata_o),
  .wstrb_i   (m_wstrb_o),
  .ifu_rsp_i (ifu_rsp_o.valid),
  .ld_rsp_i  (lsu_rd_rsp_o.valid),
  .st_done_i (lsu_wr_rsp_o.done)
);

// File: verification/tb_bus_top.sv
`timescale 1ns/1ps

module tb_bus_top
  import bus_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'h3705_2fe7;

  typedef enum logic [1:0] {PORT_FETCH, PORT_LOAD, PORT_STORE, PORT_DUAL} port_e;

  // on dual rows data holds the fetch address
  typedef struct packed {
    port_e port;
    addr_t addr;
    data_t data;
    strb_t strb;
    data_t exp_data;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  rd_req_t ifu_req;
  rd_rsp_t ifu_rsp;
  rd_req_t lsu_rd_req;
  rd_rsp_t lsu_rd_rsp;
  wr_req_t lsu_wr_req;
  wr_rsp_t lsu_wr_rsp;
  addr_t m_araddr;
  logic  m_arvalid;
  logic  m_arready = 1'b0;
  data_t m_rdata = '0;
  logic  m_rvalid = 1'b0;
  logic  m_rready;
  addr_t m_awaddr;
  logic  m_awvalid;
  logic  m_awready = 1'b0;
  data_t m_wdata;
  strb_t m_wstrb;
  logic  m_wvalid;
  logic  m_wready = 1'b0;
  logic  m_bvalid = 1'b0;
  logic  m_bready;
  logic [7:0] tx_byte;
  logic  tx_valid;
  logic  tx_ready = 1'b0;

  // memory model state
  data_t mem [256];
  addr_t rd_addr;
  addr_t wr_addr;
  data_t wr_data;
  strb_t wr_strb;
  int ar_cnt;
  int r_cnt;
  int aw_cnt;
  int w_cnt;
  int b_cnt;
  int aw_count = 0;
  logic r_busy, aw_got, w_got, b_busy;
  logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic arvalid_l = 1'b0;
  logic rready_l = 1'b0;
  logic awvalid_l = 1'b0;
  logic wvalid_l = 1'b0;
  logic bready_l = 1'b0;

  // serial port monitor
  int tx_gap = 0;
  logic tx_valid_l = 1'b0;
  logic [7:0] tx_byte_l = 8'h00;
  logic [7:0] tx_seen [$];
  logic [7:0] tx_expect [$];

  row_t rows [$];
  int cyc = 0;
  data_t last_mtime = '0;

  bus_top #(
    .TICK_DIV (4)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .ifu_req_i    (ifu_req),
    .ifu_rsp_o    (ifu_rsp),
    .lsu_rd_req_i (lsu_rd_req),
    .lsu_rd_rsp_o (lsu_rd_rsp),
    .lsu_wr_req_i (lsu_wr_req),
    .lsu_wr_rsp_o (lsu_wr_rsp),
    .m_araddr_o   (m_araddr),
    .m_arvalid_o  (m_arvalid),
    .m_arready_i  (m_arready),
    .m_rdata_i    (m_rdata),
    .m_rvalid_i   (m_rvalid),
    .m_rready_o   (m_rready),
    .m_awaddr_o   (m_awaddr),
    .m_awvalid_o  (m_awvalid),
    .m_awready_i  (m_awready),
    .m_wdata_o    (m_wdata),
    .m_wstrb_o    (m_wstrb),
    .m_wvalid_o   (m_wvalid),
    .m_wready_i   (m_wready),
    .m_bvalid_i   (m_bvalid),
    .m_bready_o   (m_bready),
    .tx_byte_o    (tx_byte),
    .tx_valid_o   (tx_valid),
    .tx_ready_i   (tx_ready)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    if (rst)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  function automatic data_t init_word(input logic [7:0] idx);
    return {24'h0, idx} * 32'h0101_0101;
  endfunction

  function automatic int stall_cycles();
    return int'($urandom % 4);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act)
      abort_run($sformatf("Error at %0d ns: %s expected 0x%h, got 0x%h", $time, name, exp, act));
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
      abort_run($sformatf("Error at %0d ns: %s expected 0x%h, got 0x%h", $time, name, exp, act));
  endtask

  // lower bound only since the timer keeps running
  task automatic check_time(input string name, input data_t lower, input data_t act);
    if (act < lower)
      abort_run($sformatf("Error at %0d ns: %s expected at least 0x%h, got 0x%h",
                          $time, name, lower, act));
  endtask

  // AXI4-Lite slave that sees a handshake one negedge after both were high
  always @(negedge clk)
  begin
    ar_fire = m_arready && arvalid_l;
    r_fire  = m_rvalid && rready_l;
    aw_fire = m_awready && awvalid_l;
    w_fire  = m_wready && wvalid_l;
    b_fire  = m_bvalid && bready_l;
    if (rst)
    begin
      for (int i = 0; i < 256; i++)
        mem[i] = init_word(8'(i));
      m_arready = 1'b0;
      m_rvalid  = 1'b0;
      m_awready = 1'b0;
      m_wready  = 1'b0;
      m_bvalid  = 1'b0;
      r_busy = 1'b0;
      aw_got = 1'b0;
      w_got  = 1'b0;
      b_busy = 1'b0;
      ar_cnt = stall_cycles();
      aw_cnt = stall_cycles();
      w_cnt  = stall_cycles();
    end
    else
    begin
      if (ar_fire)
      begin
        m_arready = 1'b0;
        rd_addr   = m_araddr;
        if (rd_addr >= 32'd1024)
          abort_run($sformatf("read at 0x%h is outside the memory model", rd_addr));
        r_busy = 1'b1;
        r_cnt  = stall_cycles();
        ar_cnt = stall_cycles();
      end
      else if (m_arvalid && !r_busy)
      begin
        if (ar_cnt == 0)
          m_arready = 1'b1;
        else
          ar_cnt--;
      end
      if (r_fire)
      begin
        m_rvalid = 1'b0;
        r_busy   = 1'b0;
      end
      else if (r_busy && !m_rvalid)
      begin
        if (r_cnt == 0)
        begin
          m_rvalid = 1'b1;
          m_rdata  = mem[rd_addr[9:2]];
        end
        else
          r_cnt--;
      end
      if (aw_fire)
      begin
        m_awready = 1'b0;
        wr_addr   = m_awaddr;
        aw_got    = 1'b1;
        aw_cnt    = stall_cycles();
        aw_count++;
      end
      else if (m_awvalid && !aw_got)
      begin
        if (aw_cnt == 0)
          m_awready = 1'b1;
        else
          aw_cnt--;
      end
      if (w_fire)
      begin
        m_wready = 1'b0;
        wr_data  = m_wdata;
        wr_strb  = m_wstrb;
        w_got    = 1'b1;
        w_cnt    = stall_cycles();
      end
      else if (m_wvalid && !w_got)
      begin
        if (w_cnt == 0)
          m_wready = 1'b1;
        else
          w_cnt--;
      end
      if (aw_got && w_got)
      begin
        if (wr_addr >= 32'd1024)
          abort_run($sformatf("write at 0x%h is outside the memory model", wr_addr));
        for (int b = 0; b < 4; b++)
          if (wr_strb[b])
            mem[wr_addr[9:2]][8*b +: 8] = wr_data[8*b +: 8];
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_busy = 1'b1;
        b_cnt  = stall_cycles();
      end
      if (b_fire)
      begin
        m_bvalid = 1'b0;
        b_busy   = 1'b0;
      end
      else if (b_busy && !m_bvalid)
      begin
        if (b_cnt == 0)
          m_bvalid = 1'b1;
        else
          b_cnt--;
      end
    end
    arvalid_l = m_arvalid;
    rready_l  = m_rready;
    awvalid_l = m_awvalid;
    wvalid_l  = m_wvalid;
    bready_l  = m_bready;
  end

  // serial sink with random ready gaps
  always @(negedge clk)
  begin
    if (tx_ready && tx_valid_l)
      tx_seen.push_back(tx_byte_l);
    if (rst)
    begin
      tx_ready = 1'b0;
      tx_gap   = 0;
    end
    else if (tx_ready && tx_valid_l)
    begin
      tx_ready = 1'b0;
      tx_gap   = stall_cycles();
    end
    else if (tx_gap > 0)
      tx_gap--;
    else
      tx_ready = 1'b1;
    tx_valid_l = tx_valid;
    tx_byte_l  = tx_byte;
  end

  task automatic wait_read(input logic from_fetch, output data_t data, output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    data   = '0;
    while (!seen)
    begin
      @(negedge clk);
      cycles++;
      if (from_fetch && ifu_rsp.valid)
      begin
        seen = 1'b1;
        data = ifu_rsp.data;
      end
      else if (!from_fetch && lsu_rd_rsp.valid)
      begin
        seen = 1'b1;
        data = lsu_rd_rsp.data;
      end
      if (!seen && cycles >= TIMEOUT)
        abort_run("timeout waiting for a read response");
    end
  endtask

  task automatic wait_store_done();
    int cycles;
    cycles = 0;
    while (!lsu_wr_rsp.done)
    begin
      @(negedge clk);
      cycles++;
      if (!lsu_wr_rsp.done && cycles >= TIMEOUT)
        abort_run("timeout waiting for a store to complete");
    end
  endtask

  task automatic issue_fetch(input addr_t addr, input data_t exp);
    data_t rdata;
    int lat;
    ifu_req.addr  = addr;
    ifu_req.valid = 1'b1;
    wait_read(1'b1, rdata, lat);
    ifu_req.valid = 1'b0;
    check_data("ifu_rsp.data", exp, rdata);
  endtask

  task automatic load_word(input addr_t addr, input data_t exp);
    data_t rdata;
    data_t bound;
    int lat;
    bound = (cyc / 4 >= 2) ? data_t'(cyc / 4 - 2) : '0;
    lsu_rd_req.addr  = addr;
    lsu_rd_req.valid = 1'b1;
    wait_read(1'b0, rdata, lat);
    lsu_rd_req.valid = 1'b0;
    if ((addr == CLINT_MTIME_LO || addr == CLINT_MTIME_HI) && lat != 2)
      abort_run($sformatf("timer load answered after %0d cycles instead of 2", lat));
    if (addr == CLINT_MTIME_LO)
    begin
      check_time("lsu_rd_rsp.data", bound, rdata);
      check_time("lsu_rd_rsp.data", last_mtime, rdata);
      last_mtime = rdata;
    end
    else
      check_data("lsu_rd_rsp.data", exp, rdata);
  endtask

  task automatic store_word(input addr_t addr, input data_t data, input strb_t strb,
                            input data_t exp);
    int writes_before;
    writes_before = aw_count;
    lsu_wr_req.addr  = addr;
    lsu_wr_req.data  = data;
    lsu_wr_req.strb  = strb;
    lsu_wr_req.valid = 1'b1;
    wait_store_done();
    lsu_wr_req.valid = 1'b0;
    if (addr == SERIAL_PORT_ADDR)
    begin
      tx_expect.push_back(exp[7:0]);
      if (aw_count != writes_before)
        abort_run("a serial port store reached the memory model");
    end
  endtask

  // load must win arbitration over the fetch raised in the same cycle
  task automatic fetch_with_load(input addr_t ld_addr, input addr_t if_addr,
                                 input data_t ld_exp);
    data_t ld_data;
    data_t if_data;
    logic ld_done;
    logic if_done;
    int cycles;
    ld_done = 1'b0;
    if_done = 1'b0;
    cycles  = 0;
    lsu_rd_req.addr  = ld_addr;
    lsu_rd_req.valid = 1'b1;
    ifu_req.addr     = if_addr;
    ifu_req.valid    = 1'b1;
    while (!(ld_done && if_done))
    begin
      @(negedge clk);
      cycles++;
      if (lsu_rd_rsp.valid)
      begin
        ld_done = 1'b1;
        ld_data = lsu_rd_rsp.data;
        lsu_rd_req.valid = 1'b0;
      end
      if (ifu_rsp.valid)
      begin
        if (!ld_done)
          abort_run("fetch response arrived before the load response");
        if_done = 1'b1;
        if_data = ifu_rsp.data;
        ifu_req.valid = 1'b0;
      end
      if (!(ld_done && if_done) && cycles >= TIMEOUT)
        abort_run("timeout waiting for the load and fetch responses");
    end
    check_data("lsu_rd_rsp.data", ld_exp, ld_data);
    check_data("ifu_rsp.data", init_word(if_addr[9:2]), if_data);
  endtask

  task automatic check_serial_output();
    int cycles;
    cycles = 0;
    while (tx_seen.size() < tx_expect.size())
    begin
      @(negedge clk);
      cycles++;
      if (tx_seen.size() < tx_expect.size() && cycles >= TIMEOUT)
        abort_run("timeout waiting for serial port bytes");
    end
    if (tx_seen.size() != tx_expect.size())
      abort_run("serial port sent more bytes than were stored");
    foreach (tx_expect[i])
      check_byte("tx_byte_o", tx_expect[i], tx_seen[i]);
  endtask

  function automatic void fill_table();
    // fetches follow the init pattern
    rows.push_back('{PORT_FETCH, 32'h0000_0000, 32'h0, 4'h0, 32'h0000_0000});
    rows.push_back('{PORT_FETCH, 32'h0000_0004, 32'h0, 4'h0, 32'h0101_0101});
    rows.push_back('{PORT_FETCH, 32'h0000_02a8, 32'h0, 4'h0, 32'haaaa_aaaa});
    // partial strobes merge into the old word
    rows.push_back('{PORT_STORE, 32'h0000_0080, 32'hdead_beef, 4'b1010, 32'h0});
    rows.push_back('{PORT_LOAD, 32'h0000_0080, 32'h0, 4'h0, 32'hde20_be20});
    rows.push_back('{PORT_STORE, 32'h0000_0084, 32'h1234_5678, 4'b0001, 32'h0});
    rows.push_back('{PORT_LOAD, 32'h0000_0084, 32'h0, 4'h0, 32'h2121_2178});
    rows.push_back('{PORT_STORE, 32'h0000_03fc, 32'h0bad_f00d, 4'b1111, 32'h0});
    rows.push_back('{PORT_FETCH, 32'h0000_03fc, 32'h0, 4'h0, 32'h0bad_f00d});
    // serial port takes the low byte only
    rows.push_back('{PORT_STORE, SERIAL_PORT_ADDR, 32'h0000_0041, 4'b0001, 32'h0000_0041});
    rows.push_back('{PORT_STORE, SERIAL_PORT_ADDR, 32'h1234_5642, 4'b0001, 32'h0000_0042});
    rows.push_back('{PORT_STORE, SERIAL_PORT_ADDR, 32'hffff_ff43, 4'b0001, 32'h0000_0043});
    rows.push_back('{PORT_STORE, SERIAL_PORT_ADDR, 32'h0000_0a44, 4'b0001, 32'h0000_0044});
    // timer words
    rows.push_back('{PORT_LOAD, CLINT_MTIME_LO, 32'h0, 4'h0, 32'h0});
    rows.push_back('{PORT_LOAD, CLINT_MTIME_LO, 32'h0, 4'h0, 32'h0});
    rows.push_back('{PORT_LOAD, CLINT_MTIME_HI, 32'h0, 4'h0, 32'h0});
    rows.push_back('{PORT_LOAD, CLINT_MTIME_LO, 32'h0, 4'h0, 32'h0});
    rows.push_back('{PORT_DUAL, 32'h0000_0080, 32'h0000_00c4, 4'h0, 32'hde20_be20});
    rows.push_back('{PORT_DUAL, 32'h0000_03fc, 32'h0000_01f0, 4'h0, 32'h0bad_f00d});
    rows.push_back('{PORT_LOAD, 32'h0000_0100, 32'h0, 4'h0, 32'h4040_4040});
  endfunction

  initial
  begin
    void'($urandom(SEED));
    ifu_req    = '0;
    lsu_rd_req = '0;
    lsu_wr_req = '0;
    fill_table();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (m_arvalid || m_awvalid || m_wvalid || m_rready || m_bready || tx_valid ||
        ifu_rsp.valid || lsu_rd_rsp.valid || lsu_wr_rsp.done)
      abort_run("a valid, ready or response output was high after reset");
    foreach (rows[i])
    begin
      // one idle cycle between rows
      @(negedge clk);
      case (rows[i].port)
        PORT_FETCH: issue_fetch(rows[i].addr, rows[i].exp_data);
        PORT_LOAD:  load_word(rows[i].addr, rows[i].exp_data);
        PORT_STORE: store_word(rows[i].addr, rows[i].data, rows[i].strb, rows[i].exp_data);
        default:    fetch_with_load(rows[i].addr, rows[i].data, rows[i].exp_data);
      endcase
    end
    check_serial_output();
    $display("Testbench passed");
    $finish;
  end

endmodule
